// File: hw/lsu_pkg.sv
// load/store unit types for the core interface and the credit-based memory bus
package lsu_pkg;

  // access width in bytes: 1, 2, 4, 8
  typedef enum logic [1:0] {
    MEM_BYTE   = 2'd0,
    MEM_HALF   = 2'd1,
    MEM_WORD   = 2'd2,
    MEM_DOUBLE = 2'd3
  } mem_size_e;

  // bus data word, read whole or per byte lane
  typedef union packed {
    logic [63:0]     dword;
    logic [7:0][7:0] bytes;  // lane 0 at the lowest address
  } mem_word_u;

  // access from the core
  typedef struct packed {
    logic [63:0] addr;
    logic [63:0] wdata;  // rs2, low bytes used
    logic        write;
    mem_size_e   size;
    logic        sext;   // loads only
  } lsu_req_t;

  // result to the core
  typedef struct packed {
    logic [63:0] rdata;       // extended load data, zero for stores
    logic        write;
    logic        misaligned;
  } lsu_rsp_t;

  // request on the memory bus, data already lane aligned
  typedef struct packed {
    logic [63:0] addr;
    mem_word_u   wdata;
    logic [7:0]  be;
    logic        write;
  } bus_req_t;

  typedef struct packed {
    mem_word_u rdata;
    logic      write;
  } bus_rsp_t;

endpackage

// File: hw/store_align.sv
// store aligner, moves rs2 bytes and their byte enables into the addressed lanes
`timescale 1ns/1ps

module store_align (
  input  logic [2:0]         addr_i,
  input  lsu_pkg::mem_size_e size_i,
  input  logic [63:0]        wdata_i,
  output lsu_pkg::mem_word_u wdata_o,
  output logic [7:0]         be_o
);
  import lsu_pkg::*;

  logic [3:0] nbytes;

  always_comb begin
    case (size_i)
      MEM_BYTE: nbytes = 4'd1;
      MEM_HALF: nbytes = 4'd2;
      MEM_WORD: nbytes = 4'd4;
      default:  nbytes = 4'd8;
    endcase
  end

  // rs2 byte k lands in lane offset+k
  // only aligned accesses reach the bus, so the lane never wraps there
  always_comb begin
    wdata_o.dword = '0;
    be_o          = '0;
    for (int k = 0; k < 8; k++) begin
      if (k < nbytes) begin
        wdata_o.bytes[addr_i + 3'(k)] = wdata_i[8*k +: 8];
        be_o[addr_i + 3'(k)]          = 1'b1;
      end
    end
  end

endmodule

// File: hw/load_extend.sv
// load extender, pulls the addressed lanes from a bus word and extends to 64 bits
`timescale 1ns/1ps

module load_extend (
  input  logic [2:0]         offset_i,
  input  lsu_pkg::mem_size_e size_i,
  input  logic               sext_i,
  input  lsu_pkg::mem_word_u rdata_i,
  output logic [63:0]        rdata_o
);
  import lsu_pkg::*;

  logic [63:0] raw;  // lanes rotated down so the access starts at byte 0
  logic        top;
  logic        fill;

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      raw[8*k +: 8] = rdata_i.bytes[offset_i + 3'(k)];
    end
  end

  always_comb begin
    case (size_i)
      MEM_BYTE: top = raw[7];
      MEM_HALF: top = raw[15];
      MEM_WORD: top = raw[31];
      default:  top = raw[63];
    endcase
  end

  assign fill = sext_i & top;  // zero fill for unsigned loads

  always_comb begin
    case (size_i)
      MEM_BYTE: rdata_o = {{56{fill}}, raw[7:0]};
      MEM_HALF: rdata_o = {{48{fill}}, raw[15:0]};
      MEM_WORD: rdata_o = {{32{fill}}, raw[31:0]};
      default:  rdata_o = raw;
    endcase
  end

endmodule

// File: hw/lsu_ctrl.sv
// load/store control, alignment check, bus credits and in-order response tracking
`timescale 1ns/1ps

module lsu_ctrl #(
  parameter int NUM_CREDITS = 4
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              lsu_req_valid_i,
  input  lsu_pkg::lsu_req_t lsu_req_i,
  output logic              lsu_req_ready_o,
  output logic              lsu_rsp_valid_o,
  output lsu_pkg::lsu_rsp_t lsu_rsp_o,
  output logic              bus_req_valid_o,
  output lsu_pkg::bus_req_t bus_req_o,
  input  logic              bus_credit_i,
  input  logic              bus_rsp_valid_i,
  input  lsu_pkg::bus_rsp_t bus_rsp_i
);
  import lsu_pkg::*;

  localparam int PTR_W = (NUM_CREDITS > 1) ? $clog2(NUM_CREDITS) : 1;
  localparam int CNT_W = $clog2(NUM_CREDITS + 1);

  typedef struct packed {
    mem_size_e  size;
    logic       sext;
    logic [2:0] offset;
    logic       write;
    logic       bypass;  // misaligned, never sent to the bus
  } ld_info_t;

  ld_info_t         q_mem [NUM_CREDITS];
  ld_info_t         head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_cnt;
  logic [CNT_W-1:0] credit_cnt;
  logic             accept;
  logic             misaligned;
  logic             direct;
  logic             push;
  logic             pop;
  mem_word_u        st_wdata;
  logic [7:0]       st_be;
  logic [63:0]      ld_data;

  always_comb begin
    case (lsu_req_i.size)
      MEM_BYTE: misaligned = 1'b0;
      MEM_HALF: misaligned = lsu_req_i.addr[0];
      MEM_WORD: misaligned = |lsu_req_i.addr[1:0];
      default:  misaligned = |lsu_req_i.addr[2:0];
    endcase
  end

  // a request still waiting in bus_req_o already holds a credit
  assign lsu_req_ready_o = (credit_cnt > CNT_W'(bus_req_valid_o)) &&
                           (q_cnt != CNT_W'(NUM_CREDITS));
  assign accept = lsu_req_valid_i & lsu_req_ready_o;
  assign direct = accept & misaligned & (q_cnt == '0);  // nothing older to wait for
  assign push   = accept & ~direct;
  assign head   = q_mem[rd_ptr];
  assign pop    = (q_cnt != '0) & (head.bypass | bus_rsp_valid_i);

  store_align u_store_align (
    .addr_i  (lsu_req_i.addr[2:0]),
    .size_i  (lsu_req_i.size),
    .wdata_i (lsu_req_i.wdata),
    .wdata_o (st_wdata),
    .be_o    (st_be)
  );

  load_extend u_load_extend (
    .offset_i (head.offset),
    .size_i   (head.size),
    .sext_i   (head.sext),
    .rdata_i  (bus_rsp_i.rdata),
    .rdata_o  (ld_data)
  );

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= '{size:   lsu_req_i.size,
                         sext:   lsu_req_i.sext,
                         offset: lsu_req_i.addr[2:0],
                         write:  lsu_req_i.write,
                         bypass: misaligned};
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      q_cnt           <= '0;
      credit_cnt      <= CNT_W'(NUM_CREDITS);
      bus_req_valid_o <= 1'b0;
      lsu_rsp_valid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(NUM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(NUM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
      case ({bus_req_valid_o, bus_credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // spent as the request leaves
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      bus_req_valid_o <= accept & ~misaligned;
      lsu_rsp_valid_o <= direct | pop;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bus_req_o.addr  <= lsu_req_i.addr;
      bus_req_o.wdata <= st_wdata;
      bus_req_o.be    <= st_be;
      bus_req_o.write <= lsu_req_i.write;
    end
  end

  always_ff @(posedge clk) begin
    if (direct) begin
      lsu_rsp_o.rdata      <= '0;
      lsu_rsp_o.write      <= lsu_req_i.write;
      lsu_rsp_o.misaligned <= 1'b1;
    end else if (pop) begin
      lsu_rsp_o.rdata      <= (head.bypass || bus_rsp_i.write) ? '0 : ld_data;
      lsu_rsp_o.write      <= head.write;
      lsu_rsp_o.misaligned <= head.bypass;
    end
  end

endmodule

// File: hw/data_ram.sv
// bus-slave data memory, fixed latency pipeline with byte-enable writes and credit return
`timescale 1ns/1ps

module data_ram #(
  parameter int NUM_CREDITS = 4,
  parameter int RAM_LATENCY = 2,
  parameter int MEM_WORDS   = 256
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              bus_req_valid_i,
  input  lsu_pkg::bus_req_t bus_req_i,
  output logic              bus_credit_o,
  output logic              bus_rsp_valid_o,
  output lsu_pkg::bus_rsp_t bus_rsp_o
);
  import lsu_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int OCC_W = $clog2(NUM_CREDITS + 1);

  mem_word_u              mem [MEM_WORDS];
  bus_req_t               pipe_req [RAM_LATENCY];
  logic [RAM_LATENCY-1:0] pipe_vld;
  bus_req_t               last;
  logic [IDX_W-1:0]       idx;
  logic [OCC_W-1:0]       occ;  // slots held by requests in the pipeline
  logic                   take;

  // a request beyond the credit budget finds no slot and is dropped
  assign take = bus_req_valid_i && (occ != OCC_W'(NUM_CREDITS));
  assign last = pipe_req[RAM_LATENCY-1];
  assign idx  = IDX_W'((last.addr >> 3) % MEM_WORDS);  // wraps

  assign bus_rsp_valid_o = pipe_vld[RAM_LATENCY-1];
  assign bus_credit_o    = pipe_vld[RAM_LATENCY-1];  // slot freed with the response

  always_comb begin
    bus_rsp_o.rdata = mem[idx];
    bus_rsp_o.write = last.write;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pipe_vld <= '0;
      occ      <= '0;
    end else begin
      pipe_vld[0] <= take;
      for (int i = 1; i < RAM_LATENCY; i++) begin
        pipe_vld[i] <= pipe_vld[i-1];
      end
      case ({take, bus_credit_o})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    pipe_req[0] <= bus_req_i;
    for (int i = 1; i < RAM_LATENCY; i++) begin
      pipe_req[i] <= pipe_req[i-1];
    end
  end

  // write at the last stage, after any older read of the same word
  always_ff @(posedge clk) begin
    if (pipe_vld[RAM_LATENCY-1] && last.write) begin
      for (int b = 0; b < 8; b++) begin
        if (last.be[b]) begin
          mem[idx].bytes[b] <= last.wdata.bytes[b];
        end
      end
    end
  end

endmodule

// File: hw/mem_subsys_top.sv
// memory subsystem top, load/store unit wired to the data memory over the credit bus
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int NUM_CREDITS = 4,
  parameter int RAM_LATENCY = 2,
  parameter int MEM_WORDS   = 256
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              lsu_req_valid_i,
  input  lsu_pkg::lsu_req_t lsu_req_i,
  output logic              lsu_req_ready_o,
  output logic              lsu_rsp_valid_o,
  output lsu_pkg::lsu_rsp_t lsu_rsp_o
);
  import lsu_pkg::*;

  logic     bus_req_valid;
  bus_req_t bus_req;
  logic     bus_credit;
  logic     bus_rsp_valid;
  bus_rsp_t bus_rsp;

  lsu_ctrl #(
    .NUM_CREDITS (NUM_CREDITS)
  ) u_lsu_ctrl (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_req_ready_o (lsu_req_ready_o),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .lsu_rsp_o       (lsu_rsp_o),
    .bus_req_valid_o (bus_req_valid),
    .bus_req_o       (bus_req),
    .bus_credit_i    (bus_credit),
    .bus_rsp_valid_i (bus_rsp_valid),
    .bus_rsp_i       (bus_rsp)
  );

  data_ram #(
    .NUM_CREDITS (NUM_CREDITS),
    .RAM_LATENCY (RAM_LATENCY),
    .MEM_WORDS   (MEM_WORDS)
  ) u_data_ram (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .bus_req_valid_i (bus_req_valid),
    .bus_req_i       (bus_req),
    .bus_credit_o    (bus_credit),
    .bus_rsp_valid_o (bus_rsp_valid),
    .bus_rsp_o       (bus_rsp)
  );

endmodule

// File: testbench/mem_subsys_checker.sv
// credit protocol checker for the load/store control, bound into every lsu_ctrl
`timescale 1ns/1ps

module mem_subsys_checker #(
  parameter int NUM_CREDITS = 4
) (
  input logic                             clk,
  input logic                             arst_n_i,
  input logic                             bus_req_valid_i,
  input logic [$clog2(NUM_CREDITS+1)-1:0] credit_cnt_i,
  input logic                             lsu_rsp_valid_i
);

  int fail_cnt = 0;  // failed assertions so far

  credit_spend: assert property (@(posedge clk) disable iff (!arst_n_i)
    bus_req_valid_i |-> credit_cnt_i != '0)
    else begin
      $error("bus request sent while no credit was left");
      fail_cnt++;
    end

  credit_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
    credit_cnt_i <= NUM_CREDITS)
    else begin
      $error("credit count above the number of buffer slots");
      fail_cnt++;
    end

  // no core response may leak out while reset is held
  rsp_in_reset: assert property (@(posedge clk) !arst_n_i |-> !lsu_rsp_valid_i)
    else begin
      $error("core response valid during reset");
      fail_cnt++;
    end

endmodule

bind lsu_ctrl mem_subsys_checker #(
  .NUM_CREDITS (NUM_CREDITS)
) u_checker (
  .clk             (clk),
  .arst_n_i        (arst_n_i),
  .bus_req_valid_i (bus_req_valid_o),
  .credit_cnt_i    (credit_cnt),
  .lsu_rsp_valid_i (lsu_rsp_valid_o)
);

// File: testbench/tb_mem_subsys.sv
// testbench for the memory subsystem, directed load/store tests against a byte model
`timescale 1ns/1ps

module tb_mem_subsys;
  import lsu_pkg::*;

  localparam int NUM_CREDITS = 4;
  localparam int RAM_LATENCY = 4;  // long enough for the credits to run out
  localparam int MEM_WORDS   = 256;
  localparam int TIMEOUT     = 200;

  logic       clk;
  logic       arst_n_i;
  logic       lsu_req_valid_i;
  lsu_req_t   lsu_req_i;
  logic       lsu_req_ready_o;
  logic       lsu_rsp_valid_o;
  lsu_rsp_t   lsu_rsp_o;

  logic [7:0] ref_mem [MEM_WORDS*8];  // reference memory, one entry per byte
  lsu_rsp_t   exp_q [$];
  lsu_rsp_t   mon_exp;
  integer     seed;
  int         value_errs;
  int         timeout_errs;
  int         assert_errs;
  int         rsp_count;
  logic       ready_floor;  // and of every ready seen while requesting

  mem_subsys_top #(
    .NUM_CREDITS (NUM_CREDITS),
    .RAM_LATENCY (RAM_LATENCY),
    .MEM_WORDS   (MEM_WORDS)
  ) UUT (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_req_i       (lsu_req_i),
    .lsu_req_ready_o (lsu_req_ready_o),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .lsu_rsp_o       (lsu_rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic compare_rsp(input lsu_rsp_t got, input lsu_rsp_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR @ %0t: %s got rdata=%h write=%b mis=%b, expected rdata=%h write=%b mis=%b",
               $time, what, got.rdata, got.write, got.misaligned,
               exp.rdata, exp.write, exp.misaligned);
      value_errs++;
    end
  endtask

  task automatic compare_ready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR @ %0t: %s got %b expected %b", $time, what, got, exp);
      value_errs++;
    end
  endtask

  function automatic int size_bytes(mem_size_e size);
    return 1 << size;
  endfunction

  function automatic int byte_idx(logic [63:0] addr);
    return int'(addr % (MEM_WORDS * 8));  // wraps like the RAM
  endfunction

  function automatic logic is_misaligned(logic [63:0] addr, mem_size_e size);
    return (addr % size_bytes(size)) != 0;
  endfunction

  // low bytes from the model, the rest filled with copies of the sign
  function automatic logic [63:0] expected_load(logic [63:0] addr, mem_size_e size, logic sext);
    logic [63:0] val;
    logic        neg;
    int          n;
    n   = size_bytes(size);
    neg = sext & ref_mem[byte_idx(addr + n - 1)][7];
    for (int i = 0; i < 8; i++) begin
      if (i < n) begin
        val[8*i +: 8] = ref_mem[byte_idx(addr + i)];
      end else begin
        val[8*i +: 8] = {8{neg}};
      end
    end
    return val;
  endfunction

  function automatic lsu_req_t make_req(logic [63:0] addr, logic [63:0] wdata, logic write,
                                        mem_size_e size, logic sext);
    lsu_req_t req;
    req.addr  = addr;
    req.wdata = wdata;
    req.write = write;
    req.size  = size;
    req.sext  = sext;
    return req;
  endfunction

  // hand one access to the DUT, record its expected response, update the model
  task automatic issue(input lsu_req_t req);
    lsu_rsp_t exp;
    int       waited;
    waited          = 0;
    lsu_req_valid_i = 1'b1;
    lsu_req_i       = req;
    while (!lsu_req_ready_o && waited < TIMEOUT) begin
      ready_floor = 1'b0;
      @(negedge clk);
      waited++;
    end
    if (!lsu_req_ready_o) begin
      $display("timeout: access to address %h was never accepted", req.addr);
      timeout_errs++;
      lsu_req_valid_i = 1'b0;
      return;
    end
    exp.write      = req.write;
    exp.misaligned = is_misaligned(req.addr, req.size);
    exp.rdata      = '0;
    if (!exp.misaligned && !req.write) begin
      exp.rdata = expected_load(req.addr, req.size, req.sext);
    end
    if (!exp.misaligned && req.write) begin
      for (int i = 0; i < size_bytes(req.size); i++) begin
        ref_mem[byte_idx(req.addr + i)] = req.wdata[8*i +: 8];
      end
    end
    exp_q.push_back(exp);
    @(negedge clk);  // transfer on the rising edge in between
    lsu_req_valid_i = 1'b0;
  endtask

  task automatic drain(input string what);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d responses still missing after %s", exp_q.size(), what);
      timeout_errs++;
      exp_q.delete();
    end
  endtask

  // responses come back in issue order
  always @(negedge clk) begin
    if (arst_n_i && lsu_rsp_valid_o) begin
      rsp_count++;
      if (exp_q.size() == 0) begin
        $display("ERROR @ %0t: response with no access outstanding", $time);
        value_errs++;
      end else begin
        mon_exp = exp_q.pop_front();
        compare_rsp(lsu_rsp_o, mon_exp, "response");
      end
    end
  end

  task automatic test_reset();
    int seen;
    compare_ready(lsu_req_ready_o, 1'b1, "ready after reset");
    seen = rsp_count;
    repeat (8) @(negedge clk);
    if (rsp_count != seen) begin
      $display("ERROR @ %0t: response appeared while the core was idle", $time);
      value_errs++;
    end
  endtask

  task automatic test_double();
    issue(make_req(64'h40, {$random(seed), $random(seed)}, 1'b1, MEM_DOUBLE, 1'b0));
    issue(make_req(64'h40, '0, 1'b0, MEM_DOUBLE, 1'b0));
    drain("doubleword store and load");
  endtask

  task automatic test_lanes();
    logic [63:0] base;
    base = 64'h80;
    issue(make_req(base, {$random(seed), $random(seed)}, 1'b1, MEM_DOUBLE, 1'b0));
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        issue(make_req(base + off, {$random(seed), $random(seed)}, 1'b1, mem_size_e'(sz), 1'b0));
        issue(make_req(base, '0, 1'b0, MEM_DOUBLE, 1'b0));  // other lanes untouched
      end
    end
    // mixed sign bits in every size
    issue(make_req(base, 64'h7123_ff45_8001_80fe, 1'b1, MEM_DOUBLE, 1'b0));
    for (int sz = 0; sz < 4; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        issue(make_req(base + off, '0, 1'b0, mem_size_e'(sz), 1'b0));
        issue(make_req(base + off, '0, 1'b0, mem_size_e'(sz), 1'b1));
      end
    end
    drain("lane stores and loads");
  endtask

  task automatic test_burst();
    mem_size_e size;
    int        off;
    for (int k = 0; k < 8; k++) begin
      issue(make_req(64'h100 + 8*k, {$random(seed), $random(seed)}, 1'b1, MEM_DOUBLE, 1'b0));
    end
    drain("burst region fill");
    ready_floor = 1'b1;
    for (int k = 0; k < 40; k++) begin
      size = mem_size_e'($random(seed) & 3);
      off  = $random(seed) & 63;
      off  = off - (off % size_bytes(size));
      issue(make_req(64'h100 + off, {$random(seed), $random(seed)}, 1'($random(seed) & 1),
                     size, 1'($random(seed) & 1)));
    end
    drain("random burst");
    compare_ready(ready_floor, 1'b0, "lowest ready during burst");
    compare_ready(lsu_req_ready_o, 1'b1, "ready after burst");
  endtask

  task automatic test_misaligned();
    issue(make_req(64'h180, 64'h0123_4567_89ab_cdef, 1'b1, MEM_DOUBLE, 1'b0));
    issue(make_req(64'h181, {$random(seed), $random(seed)}, 1'b1, MEM_HALF, 1'b0));
    issue(make_req(64'h182, {$random(seed), $random(seed)}, 1'b1, MEM_WORD, 1'b0));
    issue(make_req(64'h184, {$random(seed), $random(seed)}, 1'b1, MEM_DOUBLE, 1'b0));
    issue(make_req(64'h183, '0, 1'b0, MEM_WORD, 1'b1));
    issue(make_req(64'h180, '0, 1'b0, MEM_DOUBLE, 1'b0));
    drain("misaligned behind aligned");
    issue(make_req(64'h185, {$random(seed), $random(seed)}, 1'b1, MEM_HALF, 1'b0));  // idle queue
    drain("misaligned alone");
    issue(make_req(64'h180, '0, 1'b0, MEM_DOUBLE, 1'b0));
    drain("reload after misaligned");
  endtask

  initial begin
    seed            = 61;
    value_errs      = 0;
    timeout_errs    = 0;
    rsp_count       = 0;
    ready_floor     = 1'b1;
    arst_n_i        = 1'b0;
    lsu_req_valid_i = 1'b0;
    lsu_req_i       = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    test_reset();
    test_double();
    test_lanes();
    test_burst();
    test_misaligned();
    assert_errs = UUT.u_lsu_ctrl.u_checker.fail_cnt;
    $display("errors: %0d value, %0d timeout, %0d assertion",
             value_errs, timeout_errs, assert_errs);
    if (value_errs == 0 && timeout_errs == 0 && assert_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
hw/lsu_pkg.sv
hw/store_align.sv
hw/load_extend.sv
hw/lsu_ctrl.sv
hw/data_ram.sv
hw/mem_subsys_top.sv
testbench/mem_subsys_checker.sv
testbench/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  # design, in compile order
  - files:
      - hw/lsu_pkg.sv
      - hw/store_align.sv
      - hw/load_extend.sv
      - hw/lsu_ctrl.sv
      - hw/data_ram.sv
      - hw/mem_subsys_top.sv

  # simulation only
  - target: test
    files:
      - testbench/mem_subsys_checker.sv
      - testbench/tb_mem_subsys.sv
